// File: common/uart_defines.svh
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// 61 gives 7x oversampling of 115200 baud at 50 MHz
`define UART_SAMPLE_DIV 61

// entries per FIFO as a power of two
`define UART_FIFO_DEPTH 4

// register address width
`define UART_ADDR_W 2

`endif

// File: common/uart_pkg.sv
`default_nettype none

`include "uart_defines.svh"

package uart_pkg;

    // one character as it travels on the line
    typedef logic [7:0] uart_byte_t;

    // what the receiver hands over per frame
    typedef struct packed {
        uart_byte_t data;
        logic       frame_error;
    } rx_entry_t;

    typedef logic [$clog2(`UART_FIFO_DEPTH + 1)-1:0] fifo_level_t;

endpackage

`default_nettype wire

// File: common/uart_regs_pkg.sv
`default_nettype none

`include "uart_defines.svh"

package uart_regs_pkg;

    typedef enum logic [`UART_ADDR_W-1:0] {
        REG_DATA   = 0,
        REG_STATUS = 1,
        REG_ERRCNT = 2
    } uart_reg_e;

    // bit positions in the status byte
    localparam int STAT_RX_AVAIL    = 0;
    localparam int STAT_RX_HEAD_ERR = 1;
    localparam int STAT_RX_OVERFLOW = 2;
    localparam int STAT_TX_FULL     = 3;
    localparam int STAT_TX_IDLE     = 4;

endpackage

`default_nettype wire

// File: common/uart_byte_if.sv
`timescale 1ns/1ps
`default_nettype none

interface uart_byte_if;
    import uart_pkg::*;

    logic       tx_vld;
    uart_byte_t tx_data;
    logic       tx_busy;
    logic       rx_vld;
    uart_byte_t rx_data;
    logic       rx_frame_error;

    modport reg_side (
        output tx_vld,
        output tx_data,
        input  tx_busy,
        input  rx_vld,
        input  rx_data,
        input  rx_frame_error
    );

    modport framer_side (
        input  tx_vld,
        input  tx_data,
        output tx_busy,
        output rx_vld,
        output rx_data,
        output rx_frame_error
    );

endinterface

`default_nettype wire

// File: uart/uart_framer.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_defines.svh"

module uart_framer #(
    parameter int sample_div = `UART_SAMPLE_DIV
)
(
    input  wire logic         clk_50,
    input  wire logic         rst,
    uart_byte_if.framer_side  link,
    output logic              uart_tx,
    input  wire logic         uart_rx
);

    localparam int cnt_w = (sample_div > 0) ? $clog2(sample_div + 1) : 1;

    logic [cnt_w-1:0] sample_cnt;
    logic             sample_en;

    logic [6:0]       rx_sample;
    logic [2:0]       rx_bitclk_cnt;
    logic             rx_bitclk_en;
    logic [3:0]       rx_bit_cnt;
    logic             rx_busy;
    logic             rx_busy_d1;
    logic             rx_done;
    logic             rx_error;
    logic [8:0]       rx_capture;
    logic [8:0]       rx_signal_errors;
    logic             rx_falling;
    logic             rx_high;
    logic             rx_low;

    logic [8:0]       tx_shift;
    logic [2:0]       tx_bitclk_cnt;
    logic [3:0]       tx_cnt;
    logic             tx_busy;

    // seven sample enables per bit time
    always_ff @(posedge clk_50 or posedge rst)
    begin
        if (rst)
        begin
            sample_cnt <= '0;
            sample_en  <= 1'b0;
        end
        else if (sample_cnt == cnt_w'(sample_div))
        begin
            sample_cnt <= '0;
            sample_en  <= 1'b1;
        end
        else
        begin
            sample_cnt <= sample_cnt + 1'b1;
            sample_en  <= 1'b0;
        end
    end

    // clean edge, or a noisy one with one odd sample in the middle
    assign rx_falling = (rx_sample == 7'b1110000) ||
                        ((rx_sample[6:4] == 3'b110) && (rx_sample[1:0] == 2'b00));

    // two samples near mid-bit must agree, otherwise the bit is ambiguous
    assign rx_high = (rx_sample[2:1] == 2'b11);
    assign rx_low  = (rx_sample[2:1] == 2'b00);

    always_ff @(posedge clk_50 or posedge rst)
    begin
        if (rst)
            rx_sample <= '1;
        else if (sample_en)
            rx_sample <= {rx_sample[5:0], uart_rx};
    end

    always_ff @(posedge clk_50 or posedge rst)
    begin
        if (rst)
        begin
            rx_bitclk_cnt <= '0;
            rx_bitclk_en  <= 1'b0;
            rx_bit_cnt    <= '0;
            rx_busy       <= 1'b0;
        end
        else if (sample_en)
        begin
            if (!rx_busy)
            begin
                rx_bitclk_cnt <= '0;
                rx_bitclk_en  <= 1'b0;
                rx_bit_cnt    <= '0;
                rx_busy       <= rx_falling;
            end
            else
            begin
                rx_busy      <= (rx_bit_cnt != 4'd9);
                rx_bitclk_en <= (rx_bitclk_cnt == 3'd5);
                if (rx_bitclk_cnt == 3'd6)
                begin
                    rx_bitclk_cnt <= '0;
                    rx_bit_cnt    <= rx_bit_cnt + 4'd1;
                end
                else
                begin
                    rx_bitclk_cnt <= rx_bitclk_cnt + 3'd1;
                end
            end
        end
    end

    // eight data bits, first one received ends up on top, then the stop bit
    always_ff @(posedge clk_50)
    begin
        if (sample_en && rx_bitclk_en)
        begin
            rx_capture       <= {rx_capture[7:0], rx_high};
            rx_signal_errors <= {rx_signal_errors[7:0], !rx_high && !rx_low};
        end
    end

    always_ff @(posedge clk_50 or posedge rst)
    begin
        if (rst)
        begin
            rx_busy_d1 <= 1'b0;
            rx_done    <= 1'b0;
            rx_error   <= 1'b0;
        end
        else
        begin
            rx_busy_d1 <= rx_busy;
            rx_done    <= rx_busy_d1 && !rx_busy;
            if (rx_busy_d1 && !rx_busy)
                rx_error <= (rx_signal_errors != 9'd0) || !rx_capture[0];
        end
    end

    assign link.rx_vld         = rx_done;
    assign link.rx_data        = rx_capture[8:1];
    assign link.rx_frame_error = rx_error;

    // start bit goes out right after acceptance, data follows msb first
    always_ff @(posedge clk_50 or posedge rst)
    begin
        if (rst)
        begin
            tx_shift      <= '1;
            tx_bitclk_cnt <= '0;
            tx_cnt        <= '0;
            tx_busy       <= 1'b0;
        end
        else if (!tx_busy && link.tx_vld)
        begin
            tx_shift      <= {1'b0, link.tx_data};
            tx_bitclk_cnt <= '0;
            tx_cnt        <= '0;
            tx_busy       <= 1'b1;
        end
        else if (sample_en && tx_busy)
        begin
            if (tx_bitclk_cnt == 3'd6)
            begin
                tx_bitclk_cnt <= '0;
                tx_shift      <= {tx_shift[7:0], 1'b1};
                tx_cnt        <= tx_cnt + 4'd1;
                // tenth shift ends the stop bit
                if (tx_cnt == 4'd9)
                    tx_busy <= 1'b0;
            end
            else
            begin
                tx_bitclk_cnt <= tx_bitclk_cnt + 3'd1;
            end
        end
    end

    assign uart_tx      = tx_shift[8];
    assign link.tx_busy = tx_busy;

endmodule

`default_nettype wire

// File: hw/byte_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_defines.svh"

module byte_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = `UART_FIFO_DEPTH
)
(
    input  wire logic              clk_50,
    input  wire logic              rst,
    input  wire logic              push,
    input  wire payload_t          push_data,
    input  wire logic              pop,
    output payload_t               pop_data,
    output logic                   full,
    output logic                   empty,
    output uart_pkg::fifo_level_t  level
);
    import uart_pkg::*;

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

    payload_t         mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    fifo_level_t      count;
    logic             do_push;
    logic             do_pop;

    assign full     = (count == fifo_level_t'(depth));
    assign empty    = (count == '0);
    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    // head entry is visible without a pop
    assign pop_data = mem[rd_ptr];
    assign level    = count;

    always_ff @(posedge clk_50)
    begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk_50 or posedge rst)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count + fifo_level_t'(do_push) - fifo_level_t'(do_pop);
        end
    end

endmodule

`default_nettype wire

// File: hw/uart_reg_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_defines.svh"

module uart_reg_port
(
    input  wire logic                    clk_50,
    input  wire logic                    rst,
    input  wire logic                    bus_wr,
    input  wire logic                    bus_rd,
    input  wire logic [`UART_ADDR_W-1:0] bus_addr,
    input  wire uart_pkg::uart_byte_t    bus_wdata,
    output uart_pkg::uart_byte_t         bus_rdata,
    uart_byte_if.reg_side                link
);
    import uart_pkg::*;
    import uart_regs_pkg::*;

    uart_reg_e  addr;
    logic       tx_push;
    logic       tx_pop;
    logic       tx_full;
    logic       tx_empty;
    uart_byte_t tx_head;
    logic       rx_pop;
    logic       rx_full;
    logic       rx_empty;
    rx_entry_t  rx_in;
    rx_entry_t  rx_head;
    logic       rx_overflow;
    logic [7:0] err_cnt;
    uart_byte_t status;

    assign addr    = uart_reg_e'(bus_addr);
    assign tx_push = bus_wr && (addr == REG_DATA);
    assign tx_pop  = link.tx_vld && !link.tx_busy;
    assign rx_pop  = bus_rd && (addr == REG_DATA);
    assign rx_in   = '{data: link.rx_data, frame_error: link.rx_frame_error};

    byte_fifo #(.payload_t(uart_byte_t), .depth(`UART_FIFO_DEPTH)) tx_fifo (
        .clk_50    (clk_50),
        .rst       (rst),
        .push      (tx_push),
        .push_data (bus_wdata),
        .pop       (tx_pop),
        .pop_data  (tx_head),
        .full      (tx_full),
        .empty     (tx_empty),
        .level     ()
    );

    byte_fifo #(.payload_t(rx_entry_t), .depth(`UART_FIFO_DEPTH)) rx_fifo (
        .clk_50    (clk_50),
        .rst       (rst),
        .push      (link.rx_vld),
        .push_data (rx_in),
        .pop       (rx_pop),
        .pop_data  (rx_head),
        .full      (rx_full),
        .empty     (rx_empty),
        .level     ()
    );

    // framer takes the head byte whenever it is free
    assign link.tx_vld  = !tx_empty;
    assign link.tx_data = tx_head;

    always_comb
    begin
        status                   = '0;
        status[STAT_RX_AVAIL]    = !rx_empty;
        status[STAT_RX_HEAD_ERR] = !rx_empty && rx_head.frame_error;
        status[STAT_RX_OVERFLOW] = rx_overflow;
        status[STAT_TX_FULL]     = tx_full;
        status[STAT_TX_IDLE]     = tx_empty && !link.tx_busy;
    end

    always_ff @(posedge clk_50 or posedge rst)
    begin
        if (rst)
        begin
            rx_overflow <= 1'b0;
            err_cnt     <= '0;
        end
        else
        begin
            if (bus_wr && (addr == REG_STATUS))
                rx_overflow <= 1'b0;
            // a new drop wins over a clear in the same cycle
            if (link.rx_vld && rx_full)
                rx_overflow <= 1'b1;
            if (link.rx_vld && link.rx_frame_error && (err_cnt != 8'hff))
                err_cnt <= err_cnt + 8'd1;
        end
    end

    always_ff @(posedge clk_50 or posedge rst)
    begin
        if (rst)
            bus_rdata <= '0;
        else if (bus_rd)
        begin
            case (addr)
                REG_DATA:   bus_rdata <= rx_empty ? '0 : rx_head.data;
                REG_STATUS: bus_rdata <= status;
                REG_ERRCNT: bus_rdata <= err_cnt;
                default:    bus_rdata <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/uart_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_defines.svh"

module uart_top #(
    parameter int sample_div = `UART_SAMPLE_DIV
)
(
    input  wire logic                    clk_50,
    input  wire logic                    rst,

    input  wire logic                    bus_wr,
    input  wire logic                    bus_rd,
    input  wire logic [`UART_ADDR_W-1:0] bus_addr,
    input  wire logic [7:0]              bus_wdata,
    output logic [7:0]                   bus_rdata,

    output logic                         uart_tx,
    input  wire logic                    uart_rx
);

    // byte path between register side and framer
    uart_byte_if link ();

    uart_reg_port i_reg_port (
        .clk_50    (clk_50),
        .rst       (rst),
        .bus_wr    (bus_wr),
        .bus_rd    (bus_rd),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_rdata (bus_rdata),
        .link      (link.reg_side)
    );

    uart_framer #(
        .sample_div (sample_div)
    ) i_framer (
        .clk_50  (clk_50),
        .rst     (rst),
        .link    (link.framer_side),
        .uart_tx (uart_tx),
        .uart_rx (uart_rx)
    );

endmodule

`default_nettype wire

// File: sim/tb_uart_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_defines.svh"

module tb_uart_top;
    import uart_regs_pkg::*;

    localparam int sample_div = 3;
    localparam int depth      = `UART_FIFO_DEPTH;
    // one bit time is seven sample periods
    localparam int bit_clks   = 7 * (sample_div + 1);
    localparam int max_polls  = 2000;

    logic                    clk_50 = 1'b0;
    logic                    rst;
    logic                    bus_wr;
    logic                    bus_rd;
    logic [`UART_ADDR_W-1:0] bus_addr;
    logic [7:0]              bus_wdata;
    logic [7:0]              bus_rdata;
    logic                    uart_tx;
    logic                    uart_rx;
    logic                    inj_line;

    // receive side model with one {data, frame_error} entry per frame
    logic [8:0] exp_q [$];
    logic       exp_overflow;
    logic [7:0] exp_errcnt;
    logic       exp_tx_full;
    logic       exp_tx_idle;

    logic [7:0] exp_rdata;
    string      exp_name;
    int         rd_issued;
    int         rd_checked;
    int         errors;
    int         checks;
    int         tests;
    logic       timed_out;
    integer     seed;

    always #4 clk_50 = ~clk_50;

    // both idle high, so the injector only pulls the looped-back line low
    assign uart_rx = uart_tx & inj_line;

    uart_top #(.sample_div(sample_div)) i_dut (
        .clk_50    (clk_50),
        .rst       (rst),
        .bus_wr    (bus_wr),
        .bus_rd    (bus_rd),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_rdata (bus_rdata),
        .uart_tx   (uart_tx),
        .uart_rx   (uart_rx)
    );

    // a low stop bit flags a frame error and a full receive FIFO drops the entry
    function automatic void predict_frame(input logic [7:0] data, input logic stop_bit);
        if (exp_q.size() < depth)
            exp_q.push_back({data, !stop_bit});
        else
            exp_overflow = 1'b1;
        if (!stop_bit && exp_errcnt != 8'hff)
            exp_errcnt = exp_errcnt + 8'd1;
    endfunction

    function automatic logic [7:0] expected_status();
        logic [7:0] s;
        s                   = 8'h00;
        s[STAT_RX_AVAIL]    = (exp_q.size() != 0);
        s[STAT_RX_HEAD_ERR] = (exp_q.size() != 0) && exp_q[0][0];
        s[STAT_RX_OVERFLOW] = exp_overflow;
        s[STAT_TX_FULL]     = exp_tx_full;
        s[STAT_TX_IDLE]     = exp_tx_idle;
        return s;
    endfunction

    function automatic logic [7:0] expected_read(input logic [1:0] addr);
        logic [8:0] entry;
        logic [7:0] value;
        value = 8'h00;
        case (addr)
            REG_DATA:
                if (exp_q.size() != 0)
                begin
                    entry = exp_q.pop_front();
                    value = entry[8:1];
                end
            REG_STATUS: value = expected_status();
            REG_ERRCNT: value = exp_errcnt;
            default:    value = 8'h00;
        endcase
        return value;
    endfunction

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        checks++;
        if (actual !== expected)
        begin
            $display("Mismatch at %0t ns: %s expected 0x%02h, got 0x%02h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic bus_write(input logic [1:0] addr, input logic [7:0] data);
        bus_wr    = 1'b1;
        bus_addr  = addr;
        bus_wdata = data;
        @(posedge clk_50);
        #1;
        bus_wr = 1'b0;
    endtask

    task automatic bus_read(input logic [1:0] addr, input logic check, input string name,
                            output logic [7:0] value);
        bus_rd   = 1'b1;
        bus_addr = addr;
        if (check)
        begin
            exp_rdata = expected_read(addr);
            exp_name  = name;
        end
        @(posedge clk_50);
        #1;
        bus_rd = 1'b0;
        value  = bus_rdata;
        if (check)
            rd_issued++;
        @(posedge clk_50);
        #1;
    endtask

    task automatic read_checked(input logic [1:0] addr, input string name);
        logic [7:0] unused;
        bus_read(addr, 1'b1, name, unused);
    endtask

    task automatic wait_status(input int bit_pos, input string what);
        logic [7:0] v;
        int         polls;
        logic       seen;
        polls = 0;
        seen  = 1'b0;
        if (!timed_out)
        begin
            while (!seen && polls < max_polls)
            begin
                bus_read(REG_STATUS, 1'b0, "", v);
                seen = v[bit_pos];
                polls++;
            end
            if (!seen)
            begin
                $display("timeout: status bit %s still clear after %0d polls", what, polls);
                timed_out = 1'b1;
                errors++;
            end
        end
    endtask

    // start bit, data msb first, then the chosen stop bit and one idle bit
    task automatic send_frame(input logic [7:0] data, input logic stop_bit);
        logic [9:0] bits;
        bits = {1'b0, data, stop_bit};
        for (int i = 9; i >= 0; i--)
        begin
            inj_line = bits[i];
            repeat (bit_clks) @(posedge clk_50);
            #1;
        end
        inj_line = 1'b1;
        repeat (bit_clks) @(posedge clk_50);
        #1;
    endtask

    task automatic end_test(input string name, input int mark);
        tests++;
        if (errors == mark)
            $display("test %0d %s: passed", tests, name);
        else
            $display("test %0d %s: failed with %0d errors", tests, name, errors - mark);
    endtask

    // compares each checked register read once its data is registered
    initial
    begin
        rd_checked = 0;
        forever
        begin
            @(negedge clk_50);
            if (rd_checked != rd_issued)
            begin
                check_value({"bus_rdata ", exp_name}, exp_rdata, bus_rdata);
                rd_checked = rd_issued;
            end
        end
    end

    initial
    begin
        logic [7:0] b;
        logic [7:0] burst [depth + 2];
        int         mark;
        rst          = 1'b1;
        bus_wr       = 1'b0;
        bus_rd       = 1'b0;
        bus_addr     = '0;
        bus_wdata    = 8'h00;
        inj_line     = 1'b1;
        exp_overflow = 1'b0;
        exp_errcnt   = 8'h00;
        exp_tx_full  = 1'b0;
        exp_tx_idle  = 1'b1;
        rd_issued    = 0;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        timed_out    = 1'b0;
        seed         = 33;
        repeat (2) @(posedge clk_50);
        #1;
        rst = 1'b0;

        mark = errors;
        read_checked(REG_STATUS, "status");
        read_checked(REG_ERRCNT, "errcnt");
        check_value("uart_tx", 8'h01, 8'(uart_tx));
        end_test("after reset", mark);

        mark = errors;
        for (int i = 0; i < 3; i++)
        begin
            b = 8'($random(seed));
            bus_write(REG_DATA, b);
            predict_frame(b, 1'b1);
            wait_status(STAT_RX_AVAIL, "rx_avail");
            wait_status(STAT_TX_IDLE, "tx_idle");
            read_checked(REG_STATUS, "status");
            read_checked(REG_DATA, "rx data");
            read_checked(REG_ERRCNT, "errcnt");
        end
        end_test("loopback order", mark);

        mark = errors;
        for (int i = 0; i < depth + 2; i++)
        begin
            burst[i] = 8'($random(seed));
            bus_write(REG_DATA, burst[i]);
        end
        // first frame still on the line while the TX FIFO holds depth bytes
        exp_tx_full = 1'b1;
        exp_tx_idle = 1'b0;
        read_checked(REG_STATUS, "status");
        exp_tx_full = 1'b0;
        exp_tx_idle = 1'b1;
        // framer takes the first byte at once and the next depth fill the TX FIFO,
        // so the last byte is dropped and depth+1 frames reach the receiver
        for (int i = 0; i < depth + 1; i++)
            predict_frame(burst[i], 1'b1);
        wait_status(STAT_TX_IDLE, "tx_idle");
        wait_status(STAT_RX_OVERFLOW, "rx_overflow");
        read_checked(REG_STATUS, "status");
        // one read more than the FIFO holds returns 0
        for (int i = 0; i < depth + 1; i++)
            read_checked(REG_DATA, "rx data");
        end_test("burst and overflow", mark);

        mark = errors;
        b = 8'($random(seed));
        send_frame(b, 1'b0);
        predict_frame(b, 1'b0);
        wait_status(STAT_RX_AVAIL, "rx_avail");
        read_checked(REG_STATUS, "status");
        read_checked(REG_DATA, "rx data");
        read_checked(REG_ERRCNT, "errcnt");
        b = 8'($random(seed));
        send_frame(b, 1'b1);
        predict_frame(b, 1'b1);
        wait_status(STAT_RX_AVAIL, "rx_avail");
        read_checked(REG_STATUS, "status");
        read_checked(REG_DATA, "rx data");
        end_test("framing error", mark);

        mark = errors;
        bus_write(REG_STATUS, 8'h00);
        exp_overflow = 1'b0;
        read_checked(REG_STATUS, "status");
        read_checked(REG_ERRCNT, "errcnt");
        end_test("overflow clear", mark);

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+common
common/uart_pkg.sv
common/uart_regs_pkg.sv
common/uart_byte_if.sv
uart/uart_framer.sv
hw/byte_fifo.sv
hw/uart_reg_port.sv
hw/uart_top.sv
sim/tb_uart_top.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f all.f --top-module tb_uart_top -Mdir obj_dir -o tb_uart_top
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_uart_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "NO ERRORS" "$LOG"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see $LOG"
exit 1
